// File: sim.f
hdl/spram_pkg.sv
hdl/spram_bank.sv
hdl/spram_word.sv
hdl/spram_byte_port.sv
hdl/credit_fifo.sv
hdl/mem_port_sched.sv
hdl/spram_subsys.sv
sim/spram_subsys_properties.sv
sim/tb_spram_subsys.sv

// File: Bender.yml
package:
  name: spram_subsys

sources:
  # memory subsystem, package first
  - files:
      - hdl/spram_pkg.sv
      - hdl/spram_bank.sv
      - hdl/spram_word.sv
      - hdl/spram_byte_port.sv
      - hdl/credit_fifo.sv
      - hdl/mem_port_sched.sv
      - hdl/spram_subsys.sv

  # testbench and bound assertions
  - target: test
    files:
      - sim/spram_subsys_properties.sv
      - sim/tb_spram_subsys.sv

// File: sim/tb_spram_subsys.sv
// directed testbench for the shared memory subsystem
// keeps a reference copy of the memory and a read queue per port, drives
// both requesters under credit flow control and checks every response

`timescale 1ns/100ps
`default_nettype none

module tb_spram_subsys
    import spram_pkg::*;
();

    localparam int clk_period  = 100;
    localparam int drive_dly   = 10;
    localparam int num_random  = 200;
    localparam int drain_limit = 300;
    localparam logic [31:0] rand_seed = 32'h8a32_4c04;

    // rough cycle budget of each test
    localparam int cyc_reset   = 10;
    localparam int cyc_word_rw = 100;
    localparam int cyc_be      = 200;
    localparam int cyc_lanes   = 200;
    localparam int cyc_credit  = 150;
    localparam int cyc_random  = 6 * num_random + 200;
    localparam int run_cycles  = cyc_reset + cyc_word_rw + cyc_be + cyc_lanes
                                 + cyc_credit + cyc_random + 500;

    logic                   clk;
    logic                   reset;
    logic                   w_req_valid;
    logic                   w_req_write;
    logic [word_addr_w-1:0] w_req_addr;
    logic [3:0]             w_req_be;
    logic [word_w-1:0]      w_req_wdata;
    logic                   w_credit_return;
    logic                   w_rsp_valid;
    logic [word_w-1:0]      w_rsp_rdata;
    logic                   b_req_valid;
    logic                   b_req_write;
    logic [byte_addr_w-1:0] b_req_addr;
    logic [7:0]             b_req_wdata;
    logic                   b_credit_return;
    logic                   b_rsp_valid;
    logic [7:0]             b_rsp_rdata;

    logic [word_w-1:0] ref_mem [2**word_addr_w];   // reference copy of the memory
    logic [word_w-1:0] w_exp [$];                  // word reads in flight
    logic [7:0]        b_exp [$];
    int                w_credits;
    int                b_credits;
    int                w_stalls;                   // cycles spent waiting for a credit
    int                b_stalls;
    string             test_name;
    int unsigned       seed_ret;

    spram_subsys u_spram_subsys (
        .clk             (clk),
        .reset           (reset),
        .w_req_valid     (w_req_valid),
        .w_req_write     (w_req_write),
        .w_req_addr      (w_req_addr),
        .w_req_be        (w_req_be),
        .w_req_wdata     (w_req_wdata),
        .w_credit_return (w_credit_return),
        .w_rsp_valid     (w_rsp_valid),
        .w_rsp_rdata     (w_rsp_rdata),
        .b_req_valid     (b_req_valid),
        .b_req_write     (b_req_write),
        .b_req_addr      (b_req_addr),
        .b_req_wdata     (b_req_wdata),
        .b_credit_return (b_credit_return),
        .b_rsp_valid     (b_rsp_valid),
        .b_rsp_rdata     (b_rsp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // byte enable n covers bits 8n+7:8n
    function automatic logic [word_w-1:0] merge_be(input logic [word_w-1:0] old_word,
                                                   input logic [3:0] be,
                                                   input logic [word_w-1:0] data);
        logic [word_w-1:0] result;
        result = old_word;
        for (int n = 0; n < 4; n++) begin
            if (be[n]) begin
                result[n*8 +: 8] = data[n*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string test, input port_sel_e src,
                              input logic [word_w-1:0] exp, input logic [word_w-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s: %s read expected %h, actual %h",
                               test, src.name(), exp, act));
        end
    endtask

    task automatic check_byte(input string test, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s: byte read expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic check_credits(input string test, input port_sel_e src,
                                 input int exp, input int act);
        if (act != exp) begin
            fail_run($sformatf("ERR %s: %s credits expected %0d, actual %0d",
                               test, src.name(), exp, act));
        end
    endtask

    // valid stays high after the call, so back-to-back calls send a burst
    task automatic word_req(input logic write, input logic [word_addr_w-1:0] addr,
                            input logic [3:0] be, input logic [word_w-1:0] data);
        @(posedge clk);
        #drive_dly;
        while (w_credits == 0) begin
            w_req_valid = 1'b0;
            w_stalls++;
            @(posedge clk);
            #drive_dly;
        end
        w_req_valid = 1'b1;
        w_req_write = write;
        w_req_addr  = addr;
        w_req_be    = be;
        w_req_wdata = data;
        w_credits--;
        if (write) begin
            ref_mem[addr] = merge_be(ref_mem[addr], be, data);
        end else begin
            w_exp.push_back(ref_mem[addr]);
        end
    endtask

    task automatic byte_req(input logic write, input logic [byte_addr_w-1:0] addr,
                            input logic [7:0] data);
        logic [word_addr_w-1:0] word_idx;
        logic [1:0]             lane;
        word_idx = addr[byte_addr_w-1:2];
        lane     = addr[1:0];
        @(posedge clk);
        #drive_dly;
        while (b_credits == 0) begin
            b_req_valid = 1'b0;
            b_stalls++;
            @(posedge clk);
            #drive_dly;
        end
        b_req_valid = 1'b1;
        b_req_write = write;
        b_req_addr  = addr;
        b_req_wdata = data;
        b_credits--;
        if (write) begin
            ref_mem[word_idx][lane*8 +: 8] = data;
        end else begin
            b_exp.push_back(ref_mem[word_idx][lane*8 +: 8]);
        end
    endtask

    task automatic word_release();
        @(posedge clk);
        #drive_dly;
        w_req_valid = 1'b0;
    endtask

    task automatic byte_release();
        @(posedge clk);
        #drive_dly;
        b_req_valid = 1'b0;
    endtask

    // wait for every read to come back and every credit to return
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        #drive_dly;
        w_req_valid = 1'b0;
        b_req_valid = 1'b0;
        while (w_exp.size() != 0 || b_exp.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > drain_limit) begin
                fail_run($sformatf("%s: read responses never arrived", test_name));
            end
        end
        while ((w_credits != num_credits || b_credits != num_credits)
               && waited <= drain_limit) begin
            @(posedge clk);
            waited++;
        end
        check_credits(test_name, port_word, num_credits, w_credits);
        check_credits(test_name, port_byte, num_credits, b_credits);
    endtask

    // outputs are registered or settle right after the edge
    always @(negedge clk) begin
        if (!reset) begin
            if (w_credit_return) w_credits++;
            if (b_credit_return) b_credits++;
            if (w_credits > num_credits || b_credits > num_credits) begin
                fail_run($sformatf("%s: a port got back more credits than it spent",
                                   test_name));
            end
            if (w_rsp_valid && b_rsp_valid) begin
                fail_run($sformatf("%s: both ports got a response in one cycle", test_name));
            end else if (w_rsp_valid) begin
                if (w_exp.size() == 0) begin
                    fail_run($sformatf("%s: word response with no read outstanding", test_name));
                end else begin
                    check_word(test_name, port_word, w_exp.pop_front(), w_rsp_rdata);
                end
            end else if (b_rsp_valid) begin
                if (b_exp.size() == 0) begin
                    fail_run($sformatf("%s: byte response with no read outstanding", test_name));
                end else begin
                    check_byte(test_name, b_exp.pop_front(), b_rsp_rdata);
                end
            end
        end
    end

    task automatic word_rw_pairs();
        logic [word_addr_w-1:0] low_addrs [4];
        test_name = "word_rw";
        low_addrs = '{15'h0000, 15'h0001, 15'h0123, 15'h3fff};
        for (int i = 0; i < 4; i++) begin   // same bank address in both pairs
            word_req(1'b1, low_addrs[i], 4'hf, $urandom);
            word_req(1'b1, {1'b1, low_addrs[i][13:0]}, 4'hf, $urandom);
        end
        for (int i = 0; i < 4; i++) begin
            word_req(1'b0, low_addrs[i], 4'h0, '0);
            word_req(1'b0, {1'b1, low_addrs[i][13:0]}, 4'h0, '0);
        end
        drain();
    endtask

    task automatic be_merge();
        logic [word_addr_w-1:0] addr;
        test_name = "be_merge";
        for (int be = 1; be < 16; be++) begin
            addr = 15'h0200 + 15'(be);
            word_req(1'b1, addr, 4'hf, $urandom);
            word_req(1'b1, addr, 4'(be), $urandom);
            word_req(1'b0, addr, 4'h0, '0);
        end
        drain();
    endtask

    task automatic byte_lanes();
        logic [word_addr_w-1:0] addr;
        test_name = "byte_write_lanes";
        for (int i = 0; i < 4; i++) begin
            word_req(1'b1, 15'h0300 + 15'(i), 4'hf, $urandom);
        end
        drain();
        for (int i = 0; i < 4; i++) begin   // lane i of word i
            addr = 15'h0300 + 15'(i);
            byte_req(1'b1, {addr, 2'(i)}, 8'($urandom));
        end
        drain();
        for (int i = 0; i < 4; i++) begin
            word_req(1'b0, 15'h0300 + 15'(i), 4'h0, '0);
        end
        drain();
        test_name = "byte_read_lanes";
        for (int i = 0; i < 4; i++) begin
            word_req(1'b1, 15'h4300 + 15'(i), 4'hf, $urandom);
        end
        drain();
        for (int i = 0; i < 16; i++) begin
            addr = 15'h4300 + 15'(i / 4);
            byte_req(1'b0, {addr, 2'(i % 4)}, 8'h00);
        end
        drain();
    endtask

    task automatic credit_bursts();
        test_name = "credit_flow";
        w_stalls  = 0;
        b_stalls  = 0;
        fork
            begin
                for (int i = 0; i < 8; i++) word_req(1'b1, 15'h0500 + 15'(i), 4'hf, $urandom);
                for (int i = 0; i < 8; i++) word_req(1'b0, 15'h0500 + 15'(i), 4'h0, '0);
                word_release();
            end
            begin
                for (int i = 0; i < 8; i++) begin
                    byte_req(1'b1, {15'h4500 + 15'(i), 2'(i)}, 8'($urandom));
                end
                for (int i = 0; i < 8; i++) begin
                    byte_req(1'b0, {15'h4500 + 15'(i), 2'(i)}, 8'h00);
                end
                byte_release();
            end
        join
        if (w_stalls == 0 || b_stalls == 0) begin
            fail_run("credit_flow: a burst never ran out of credits");
        end
        drain();   // every credit has to be back by now
    endtask

    task automatic random_traffic();
        logic [31:0] wr;
        logic [31:0] br;
        test_name = "random_preload";
        for (int i = 0; i < 16; i++) begin
            word_req(1'b1, 15'h0400 + 15'(i), 4'hf, $urandom);
            word_req(1'b1, 15'h4400 + 15'(i), 4'hf, $urandom);
        end
        drain();
        test_name = "random_traffic";
        fork
            begin   // word port stays in the low half
                repeat (num_random) begin
                    wr = $urandom;
                    word_req(wr[4], 15'h0400 + 15'(wr[3:0]), wr[8:5], $urandom);
                    if (wr[11:9] == 3'd0) word_release();
                end
                word_release();
            end
            begin   // byte port stays in the high half
                repeat (num_random) begin
                    br = $urandom;
                    byte_req(br[6], {15'h4400 + 15'(br[3:0]), br[5:4]}, br[15:8]);
                    if (br[18:16] == 3'd0) byte_release();
                end
                byte_release();
            end
        join
        drain();
    endtask

    initial begin
        seed_ret    = $urandom(rand_seed);
        reset       = 1'b1;
        w_req_valid = 1'b0;
        w_req_write = 1'b0;
        w_req_addr  = '0;
        w_req_be    = '0;
        w_req_wdata = '0;
        b_req_valid = 1'b0;
        b_req_write = 1'b0;
        b_req_addr  = '0;
        b_req_wdata = '0;
        w_credits   = num_credits;
        b_credits   = num_credits;
        w_stalls    = 0;
        b_stalls    = 0;
        test_name   = "reset";
        repeat (4) @(posedge clk);
        #drive_dly;
        reset = 1'b0;
        word_rw_pairs();
        be_merge();
        byte_lanes();
        credit_bursts();
        random_traffic();
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(run_cycles * clk_period);
        fail_run($sformatf("timeout: run still busy after %0d cycles in %s",
                           run_cycles, test_name));
    end

endmodule : tb_spram_subsys

`default_nettype wire

// File: sim/spram_subsys_properties.sv
// scheduler checks for the shared memory subsystem
// bound into every mem_port_sched, watches round-robin alternation between
// the queue heads and the one-cycle spacing between a read issue and its response

`timescale 1ns/100ps
`default_nettype none

module spram_subsys_properties
    import spram_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic w_head_valid,
    input logic w_pop,
    input logic b_head_valid,
    input logic b_pop,
    input logic mem_en,
    input logic mem_write,
    input logic w_rsp_valid,
    input logic b_rsp_valid
);

    logic rd_issue;

    assign rd_issue = mem_en && !mem_write;

    // a head that waited while the other port was served goes next
    a_w_after_b : assert property (@(posedge clk) disable iff (reset)
        (b_pop && w_head_valid) |=> w_pop) else $error("word head skipped after a byte issue");

    a_b_after_w : assert property (@(posedge clk) disable iff (reset)
        (w_pop && b_head_valid) |=> b_pop) else $error("byte head skipped after a word issue");

    // every read answers exactly one cycle later, and nothing else does
    a_read_rsp : assert property (@(posedge clk) disable iff (reset)
        rd_issue |=> (w_rsp_valid || b_rsp_valid)) else $error("read issue without a response");

    a_rsp_cause : assert property (@(posedge clk) disable iff (reset)
        (w_rsp_valid || b_rsp_valid) |-> $past(rd_issue))
        else $error("response without a read issue one cycle before");

    a_rsp_single : assert property (@(posedge clk) disable iff (reset)
        !(w_rsp_valid && b_rsp_valid)) else $error("both ports answered in one cycle");

endmodule : spram_subsys_properties

bind mem_port_sched spram_subsys_properties u_props (
    .clk          (clk),
    .reset        (reset),
    .w_head_valid (w_head_valid),
    .w_pop        (w_pop),
    .b_head_valid (b_head_valid),
    .b_pop        (b_pop),
    .mem_en       (mem_en),
    .mem_write    (mem_write),
    .w_rsp_valid  (w_rsp_valid),
    .b_rsp_valid  (b_rsp_valid)
);

`default_nettype wire

// File: hdl/spram_subsys.sv
// shared single-port memory subsystem
// word and byte requesters each feed a credited request queue; a
// round-robin scheduler drives the 32K x 32 memory and returns reads

`timescale 1ns/100ps
`default_nettype none

module spram_subsys
    import spram_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // word port
    input  logic                   w_req_valid,
    input  logic                   w_req_write,
    input  logic [word_addr_w-1:0] w_req_addr,
    input  logic [3:0]             w_req_be,
    input  logic [word_w-1:0]      w_req_wdata,
    output logic                   w_credit_return,
    output logic                   w_rsp_valid,
    output logic [word_w-1:0]      w_rsp_rdata,
    // byte port
    input  logic                   b_req_valid,
    input  logic                   b_req_write,
    input  logic [byte_addr_w-1:0] b_req_addr,
    input  logic [7:0]             b_req_wdata,
    output logic                   b_credit_return,
    output logic                   b_rsp_valid,
    output logic [7:0]             b_rsp_rdata
);

    word_req_t              w_push;
    word_req_t              w_head;
    word_req_t              b_word_head;     // byte head as a word command
    byte_req_t              b_push;
    byte_req_t              b_head;
    logic                   w_head_valid;
    logic                   w_pop;
    logic                   b_head_valid;
    logic                   b_pop;
    logic [word_addr_w-1:0] b_word_addr;
    logic [3:0]             b_word_be;
    logic [word_w-1:0]      b_word_wdata;
    logic                   b_issue_read;
    logic [word_w-1:0]      word_rsp_to_byte;
    logic                   mem_en;
    logic                   mem_write;
    logic [word_addr_w-1:0] mem_addr;
    logic [3:0]             mem_be;
    logic [word_w-1:0]      mem_wdata;
    logic [word_w-1:0]      mem_rdata;

    assign w_push = '{write: w_req_write, addr: w_req_addr, be: w_req_be, wdata: w_req_wdata};
    assign b_push = '{write: b_req_write, addr: b_req_addr, wdata: b_req_wdata};

    assign b_word_head = '{write: b_head.write, addr: b_word_addr, be: b_word_be,
                           wdata: b_word_wdata};

    credit_fifo #(.payload_t(word_req_t)) u_w_fifo (
        .clk           (clk),
        .reset         (reset),
        .push          (w_req_valid),
        .push_data     (w_push),
        .pop           (w_pop),
        .head_valid    (w_head_valid),
        .head_data     (w_head),
        .credit_return (w_credit_return)
    );

    credit_fifo #(.payload_t(byte_req_t)) u_b_fifo (
        .clk           (clk),
        .reset         (reset),
        .push          (b_req_valid),
        .push_data     (b_push),
        .pop           (b_pop),
        .head_valid    (b_head_valid),
        .head_data     (b_head),
        .credit_return (b_credit_return)
    );

    spram_byte_port u_byte_port (
        .clk          (clk),
        .reset        (reset),
        .req_addr     (b_head.addr),
        .req_wdata    (b_head.wdata),
        .req_write    (b_head.write),
        .issue        (b_issue_read),
        .word_addr    (b_word_addr),
        .word_be      (b_word_be),
        .word_wdata   (b_word_wdata),
        .rsp_valid_in (b_rsp_valid),
        .word_rdata   (word_rsp_to_byte),
        .byte_rdata   (b_rsp_rdata)
    );

    mem_port_sched u_sched (
        .clk              (clk),
        .reset            (reset),
        .w_head_valid     (w_head_valid),
        .w_head           (w_head),
        .w_pop            (w_pop),
        .b_head_valid     (b_head_valid),
        .b_head           (b_word_head),
        .b_pop            (b_pop),
        .mem_en           (mem_en),
        .mem_write        (mem_write),
        .mem_addr         (mem_addr),
        .mem_be           (mem_be),
        .mem_wdata        (mem_wdata),
        .mem_rdata        (mem_rdata),
        .b_issue_read     (b_issue_read),
        .w_rsp_valid      (w_rsp_valid),
        .w_rsp_rdata      (w_rsp_rdata),
        .b_rsp_valid      (b_rsp_valid),
        .word_rsp_to_byte (word_rsp_to_byte)
    );

    spram_word u_mem (
        .clk   (clk),
        .en    (mem_en),
        .write (mem_write),
        .addr  (mem_addr),
        .be    (mem_be),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule : spram_subsys

`default_nettype wire

// File: hdl/mem_port_sched.sv
// round-robin memory scheduler
// issues one queued request per cycle from the word or byte head,
// alternating when both wait, and routes each read response back to the
// port that issued it one cycle later. writes return nothing

`timescale 1ns/100ps
`default_nettype none

module mem_port_sched
    import spram_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // word queue head
    input  logic                   w_head_valid,
    input  word_req_t              w_head,
    output logic                   w_pop,
    // byte queue head, already widened to a word command
    input  logic                   b_head_valid,
    input  word_req_t              b_head,
    output logic                   b_pop,
    // memory command
    output logic                   mem_en,
    output logic                   mem_write,
    output logic [word_addr_w-1:0] mem_addr,
    output logic [3:0]             mem_be,
    output logic [word_w-1:0]      mem_wdata,
    input  logic [word_w-1:0]      mem_rdata,
    // responses
    output logic                   b_issue_read,
    output logic                   w_rsp_valid,
    output logic [word_w-1:0]      w_rsp_rdata,
    output logic                   b_rsp_valid,
    output logic [word_w-1:0]      word_rsp_to_byte
);

    port_sel_e last_served;
    port_sel_e grant_port;
    logic      grant_w;
    logic      grant_b;
    logic      rsp_pending;      // read issued last cycle
    word_req_t issue_req;

    // word wins unless the byte port waits too and word went last
    assign grant_w = w_head_valid && (!b_head_valid || last_served == port_byte);
    assign grant_b = b_head_valid && !grant_w;

    assign grant_port = grant_b ? port_byte : port_word;
    assign issue_req  = grant_b ? b_head : w_head;

    assign w_pop = grant_w;
    assign b_pop = grant_b;

    assign mem_en    = grant_w || grant_b;
    assign mem_write = mem_en && issue_req.write;
    assign mem_addr  = issue_req.addr;
    assign mem_be    = issue_req.be;
    assign mem_wdata = issue_req.wdata;

    assign b_issue_read = grant_b && !b_head.write;   // lets the adapter latch its lane

    // last_served also names the owner of the read answered this cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            last_served <= port_byte;   // word port first after reset
            rsp_pending <= 1'b0;
        end else begin
            if (mem_en) begin
                last_served <= grant_port;
            end
            rsp_pending <= mem_en && !issue_req.write;
        end
    end

    assign w_rsp_valid = rsp_pending && (last_served == port_word);
    assign b_rsp_valid = rsp_pending && (last_served == port_byte);

    // the memory output register holds the data, both ports see it
    assign w_rsp_rdata      = mem_rdata;
    assign word_rsp_to_byte = mem_rdata;

endmodule : mem_port_sched

`default_nettype wire

// File: hdl/credit_fifo.sv
// request queue with credit return
// circular queue as deep as the requester's credit count; a pushed item
// reaches the head next cycle and every pop hands one credit back

`timescale 1ns/100ps
`default_nettype none

module credit_fifo
    import spram_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     head_valid,
    output payload_t head_data,
    output logic     credit_return
);

    payload_t                       entries [num_credits];
    logic [$clog2(num_credits)-1:0] wr_ptr;
    logic [$clog2(num_credits)-1:0] rd_ptr;
    logic [$clog2(num_credits):0]   count;
    logic                           do_pop;

    // credits keep push from ever hitting a full queue
    assign do_pop = pop && head_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) entries[wr_ptr] <= push_data;
    end

    assign head_valid    = (count != '0);
    assign head_data     = entries[rd_ptr];
    assign credit_return = do_pop;     // same cycle as the pop

endmodule : credit_fifo

`default_nettype wire

// File: hdl/spram_byte_port.sv
// byte access adapter for the tracer port
// turns a byte request into a word command with the byte copied to all
// lanes and a one-hot enable, then picks the addressed byte out of the
// returned word using the lane kept from the read issue

`timescale 1ns/100ps
`default_nettype none

module spram_byte_port
    import spram_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [byte_addr_w-1:0] req_addr,
    input  logic [7:0]             req_wdata,
    input  logic                   req_write,
    input  logic                   issue,        // byte read sent to memory
    output logic [word_addr_w-1:0] word_addr,
    output logic [3:0]             word_be,
    output logic [word_w-1:0]      word_wdata,
    input  logic                   rsp_valid_in,
    input  logic [word_w-1:0]      word_rdata,
    output logic [7:0]             byte_rdata
);

    logic [1:0] lane;
    logic [1:0] lane_q;       // lane of the read in flight

    assign lane       = req_addr[1:0];
    assign word_addr  = req_addr[byte_addr_w-1:2];
    assign word_wdata = {4{req_wdata}};

    // reads need no enables
    assign word_be = req_write ? (4'b0001 << lane) : 4'b0000;

    // data comes back a cycle after issue, keep the lane until then
    always_ff @(posedge clk) begin
        if (reset) begin
            lane_q <= 2'd0;
        end else if (issue) begin
            lane_q <= lane;
        end
    end

    always_comb begin
        byte_rdata = 8'h00;
        if (rsp_valid_in) begin
            case (lane_q)
                2'd0:    byte_rdata = word_rdata[7:0];
                2'd1:    byte_rdata = word_rdata[15:8];
                2'd2:    byte_rdata = word_rdata[23:16];
                default: byte_rdata = word_rdata[31:24];
            endcase
        end
    end

endmodule : spram_byte_port

`default_nettype wire

// File: hdl/spram_word.sv
// 32K x 32 word memory
// two bank pairs, each a high and a low halfword bank, chosen by the top
// address bit. byte enables widen to nibble masks, read data steers from
// the pair that was read in the previous cycle

`timescale 1ns/100ps
`default_nettype none

module spram_word
    import spram_pkg::*;
(
    input  logic                   clk,
    input  logic                   en,
    input  logic                   write,
    input  logic [word_addr_w-1:0] addr,
    input  logic [3:0]             be,
    input  logic [word_w-1:0]      wdata,
    output logic [word_w-1:0]      rdata
);

    logic [3:0]        mask_hi;             // nibble mask for bits 31:16
    logic [3:0]        mask_lo;             // nibble mask for bits 15:0
    logic              pair_sel;
    logic              pair_sel_q;          // pair of the last read
    logic [half_w-1:0] rdata_hi [2];
    logic [half_w-1:0] rdata_lo [2];

    // each byte enable covers two nibbles
    assign mask_hi  = {be[3], be[3], be[2], be[2]};
    assign mask_lo  = {be[1], be[1], be[0], be[0]};
    assign pair_sel = addr[word_addr_w-1];

    for (genvar p = 0; p < 2; p++) begin : g_pair
        logic pair_en;

        assign pair_en = en && (pair_sel == 1'(p));

        spram_bank u_bank_hi (
            .clk   (clk),
            .en    (pair_en),
            .write (write),
            .addr  (addr[bank_addr_w-1:0]),
            .mask  (mask_hi),
            .wdata (wdata[word_w-1:half_w]),
            .rdata (rdata_hi[p])
        );

        spram_bank u_bank_lo (
            .clk   (clk),
            .en    (pair_en),
            .write (write),
            .addr  (addr[bank_addr_w-1:0]),
            .mask  (mask_lo),
            .wdata (wdata[half_w-1:0]),
            .rdata (rdata_lo[p])
        );
    end

    // the bank outputs are registered, so the select has to be too
    always_ff @(posedge clk) begin
        if (en && !write) begin
            pair_sel_q <= pair_sel;
        end
    end

    assign rdata = {rdata_hi[pair_sel_q], rdata_lo[pair_sel_q]};

endmodule : spram_word

`default_nettype wire

// File: hdl/spram_bank.sv
// behavioral single-port bank, 16K x 16
// writes the nibbles selected by the mask, read data lands in an
// output register one cycle after the command

`timescale 1ns/100ps
`default_nettype none

module spram_bank
    import spram_pkg::*;
(
    input  logic                   clk,
    input  logic                   en,
    input  logic                   write,
    input  logic [bank_addr_w-1:0] addr,
    input  logic [3:0]             mask,     // one bit per nibble
    input  logic [half_w-1:0]      wdata,
    output logic [half_w-1:0]      rdata
);

    logic [half_w-1:0] mem [2**bank_addr_w];

    always_ff @(posedge clk) begin
        if (en) begin
            if (write) begin
                for (int n = 0; n < 4; n++) begin
                    if (mask[n]) begin
                        mem[addr][n*4 +: 4] <= wdata[n*4 +: 4];
                    end
                end
            end else begin
                rdata <= mem[addr];     // holds until the next read
            end
        end
    end

endmodule : spram_bank

`default_nettype wire

// File: hdl/spram_pkg.sv
// spram subsystem definitions
// memory geometry, credit count and the request records carried through
// the request queues and the scheduler

`default_nettype none

package spram_pkg;

    // geometry of the 128 KB memory
    localparam int word_addr_w = 15;    // 32K words
    localparam int byte_addr_w = 17;    // 128K bytes
    localparam int bank_addr_w = 14;    // 16K entries per bank
    localparam int word_w      = 32;
    localparam int half_w      = 16;    // one bank is a halfword wide

    // credits per requester, also the depth of each request queue
    localparam int num_credits = 2;

    // word request as queued and issued to memory
    typedef struct packed {
        logic                   write;
        logic [word_addr_w-1:0] addr;
        logic [3:0]             be;     // bit n enables bits 8n+7:8n
        logic [word_w-1:0]      wdata;
    } word_req_t;

    // byte request from the tracer, before lane expansion
    typedef struct packed {
        logic                   write;
        logic [byte_addr_w-1:0] addr;
        logic [7:0]             wdata;
    } byte_req_t;

    // requester that owns an issued command
    typedef enum logic {
        port_word = 1'b0,
        port_byte = 1'b1
    } port_sel_e;

endpackage : spram_pkg

`default_nettype wire
